//--- Bender.yml
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_tag_ram.sv
  - src/icache_data_ram.sv
  - src/icache_replace.sv
  - src/icache_refill.sv
  - src/icache.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/mem_model.sv
      - sim/icache_tb.sv

//--- compile.f
src/icache_pkg.sv
src/icache_tag_ram.sv
src/icache_data_ram.sv
src/icache_replace.sv
src/icache_refill.sv
src/icache.sv
sim/tb_clock.sv
sim/mem_model.sv
sim/icache_tb.sv

//--- sim/icache_tb.sv
`default_nettype none

module icache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAYS             = icache_pkg::DEFAULT_WAYS;
	localparam int SETS             = icache_pkg::DEFAULT_SETS;
	localparam int LINE_WORDS       = icache_pkg::DEFAULT_LINE_WORDS;
	localparam int OFFSET_W         = $clog2(LINE_WORDS);
	localparam int INDEX_W          = $clog2(SETS);
	localparam int RESET_CYCLES     = 10;
	localparam int MAX_ACCEPT_WAIT  = 3;
	localparam int MAX_RETURN_DELAY = 6;
	localparam int RANDOM_FETCHES   = 300;
	localparam int RANDOM_WORDS     = 768; // 3 KB window is larger than the cache
	localparam icache_pkg::addr_t RANDOM_BASE = 32'h0000_4000;
	localparam int N_REQ          = 2 + LINE_WORDS + 7 + RANDOM_FETCHES + 3;
	localparam int WORST_MISS     = 4 + LINE_WORDS * (MAX_ACCEPT_WAIT + 1) + MAX_RETURN_DELAY;
	localparam int TIMEOUT_CYCLES = N_REQ * (WORST_MISS + 2) + 4 * RESET_CYCLES;

	logic              clk;
	logic              reset;
	logic              restart;
	logic              req;
	icache_pkg::addr_t addr;
	logic              addr_ok;
	logic              data_ok;
	icache_pkg::word_t rdata;
	logic              mem_req;
	icache_pkg::addr_t mem_addr;
	logic              mem_addr_ok;
	logic              mem_data_ok;
	icache_pkg::word_t mem_rdata;

	int errors;
	int checks;
	int cycle_count;
	int issued;      // addresses accepted for the current miss
	int total_reads; // all accepted memory reads

	// expected residency with one tag per way and a round robin pointer per set
	icache_pkg::addr_t model_tag   [SETS][WAYS];
	logic              model_valid [SETS][WAYS];
	int                model_ptr   [SETS];

	tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(RESET_CYCLES)) clock_inst (
		.restart (restart),
		.clk     (clk),
		.reset   (reset)
	);

	mem_model #(.MAX_ACCEPT_WAIT(MAX_ACCEPT_WAIT), .MAX_RETURN_DELAY(MAX_RETURN_DELAY)) mem_inst (
		.clk         (clk),
		.reset       (reset),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata)
	);

	icache icache_inst (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.addr        (addr),
		.addr_ok     (addr_ok),
		.data_ok     (data_ok),
		.rdata       (rdata),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata)
	);

	// memory word at the fetch address
	function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
		icache_pkg::word_t w;
		w = a >> 2;
		return (w * 32'h9e37_79b9) ^ {w[15:0], w[31:16]} ^ 32'h5a5a_0f0f;
	endfunction

	function automatic int set_of(input icache_pkg::addr_t a);
		return int'((a >> (OFFSET_W + 2)) % SETS);
	endfunction

	function automatic icache_pkg::addr_t tag_of(input icache_pkg::addr_t a);
		return a >> (OFFSET_W + 2 + INDEX_W);
	endfunction

	function automatic icache_pkg::addr_t line_of(input icache_pkg::addr_t a);
		return a & ~icache_pkg::addr_t'(LINE_WORDS * 4 - 1);
	endfunction

	function automatic icache_pkg::addr_t make_line(input int tag, input int set);
		return icache_pkg::addr_t'((tag << (OFFSET_W + 2 + INDEX_W)) | (set << (OFFSET_W + 2)));
	endfunction

	function automatic logic model_hit(input icache_pkg::addr_t a);
		for (int w = 0; w < WAYS; w++)
		begin
			if (model_valid[set_of(a)][w] && model_tag[set_of(a)][w] == tag_of(a))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic model_fill(input icache_pkg::addr_t a);
		int s;
		s = set_of(a);
		model_tag[s][model_ptr[s]]   = tag_of(a);
		model_valid[s][model_ptr[s]] = 1'b1;
		model_ptr[s]                 = (model_ptr[s] + 1) % WAYS; // oldest way goes next
	endtask

	task automatic model_clear();
		for (int s = 0; s < SETS; s++)
		begin
			model_ptr[s] = 0;
			for (int w = 0; w < WAYS; w++)
				model_valid[s][w] = 1'b0;
		end
	endtask

	task automatic check_word(input string name, input icache_pkg::word_t exp,
		input icache_pkg::word_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input icache_pkg::addr_t exp,
		input icache_pkg::addr_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// one fetch held until addr_ok and checked against the residency model
	task automatic access(input icache_pkg::addr_t a);
		logic exp_hit;
		int   waited;
		int   reads_before;
		exp_hit      = model_hit(a);
		reads_before = total_reads;
		waited       = 0;
		req  <= 1'b1;
		addr <= a;
		do
		begin
			@(posedge clk);
			waited++;
		end
		while (!addr_ok);
		check_bit("data_ok", 1'b1, data_ok);
		check_bit("hit", exp_hit, logic'(waited == 1)); // a hit answers in its own cycle
		checks++;
		if ((total_reads - reads_before) != (exp_hit ? 0 : LINE_WORDS))
		begin
			errors++;
			$display("FAILED at %0t: memory reads for %h expected %0d, got %0d",
				$time, a, exp_hit ? 0 : LINE_WORDS, total_reads - reads_before);
		end
		if (!exp_hit)
			model_fill(a);
	endtask

	task automatic idle();
		req <= 1'b0;
		@(posedge clk);
	endtask

	task automatic wait_reset_done();
		@(posedge clk);
		while (reset)
			@(posedge clk);
	endtask

	// every response is compared with the reference word
	always @(posedge clk)
	begin
		if (!reset && data_ok)
		begin
			check_bit("addr_ok", 1'b1, addr_ok);
			check_bit("mem_req", 1'b0, mem_req);
			check_word("rdata", expected_word(addr), rdata);
		end
	end

	// memory addresses of a miss run upward from the line base
	always @(posedge clk)
	begin
		if (reset)
			issued <= 0;
		else if (mem_req && mem_addr_ok)
		begin
			check_addr("mem_addr", line_of(addr) + icache_pkg::addr_t'(issued * 4), mem_addr);
			issued      <= issued + 1;
			total_reads <= total_reads + 1;
		end
		else if (addr_ok)
			issued <= 0;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("timeout: no finish after %0d cycles, %0d errors so far",
				cycle_count, errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		icache_pkg::addr_t a;
		void'($urandom(32'h9178_a3c6));
		req     = 1'b0;
		addr    = '0;
		restart = 1'b0;
		model_clear();
		wait_reset_done();

		// cold miss then the same word again and the rest of the line
		access(32'h0000_0108);
		access(32'h0000_0108);
		for (int k = 0; k < LINE_WORDS; k++)
			access(32'h0000_0100 + icache_pkg::addr_t'(k * 4));
		idle();

		// three lines in set 5 where the third evicts the first
		access(make_line(3, 5));
		access(make_line(7, 5) + 4);
		access(make_line(3, 5) + 8);
		access(make_line(7, 5));
		access(make_line(9, 5) + 12);
		access(make_line(7, 5) + 4);
		access(make_line(3, 5));
		idle();

		for (int n = 0; n < RANDOM_FETCHES; n++)
		begin
			a = RANDOM_BASE + icache_pkg::addr_t'($urandom_range(RANDOM_WORDS - 1, 0) << 2);
			access(a);
			if ($urandom_range(3, 0) == 0)
				idle();
		end
		idle();

		// line 0108 resident again and reset hits while another miss is in flight
		access(32'h0000_0108);
		req  <= 1'b1;
		addr <= 32'h0000_8000; // line never fetched before
		repeat (3)
			@(posedge clk);
		req     <= 1'b0;
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		wait_reset_done();
		model_clear();
		check_bit("addr_ok", 1'b0, addr_ok);
		check_bit("data_ok", 1'b0, data_ok);
		check_bit("mem_req", 1'b0, mem_req);
		access(32'h0000_0108);
		idle();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/mem_model.sv
`default_nettype none

module mem_model #(
	parameter int MAX_ACCEPT_WAIT  = 3, // idle cycles after an accepted address
	parameter int MAX_RETURN_DELAY = 6  // cycles from accept to data
)(
	input  logic              clk,
	input  logic              reset,
	input  logic              mem_req,
	input  icache_pkg::addr_t mem_addr,
	output logic              mem_addr_ok,
	output logic              mem_data_ok,
	output icache_pkg::word_t mem_rdata
);

	timeunit 1ns;
	timeprecision 100ps;

	logic              accept_q = 1'b0;
	logic              return_q = 1'b0;
	icache_pkg::word_t rdata_q  = '0;

	icache_pkg::addr_t pend_addr [$]; // accepted reads, oldest first
	int                pend_due  [$]; // cycle when each may return
	int                cycle;
	int                wait_cnt;

	// contents are a fixed function of the word address
	function automatic icache_pkg::word_t contents(input icache_pkg::addr_t a);
		icache_pkg::word_t w;
		w = a >> 2;
		return (w * 32'h9e37_79b9) ^ {w[15:0], w[31:16]} ^ 32'h5a5a_0f0f;
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			accept_q <= 1'b0;
			return_q <= 1'b0;
			rdata_q  <= '0;
			cycle    = 0;
			wait_cnt = 0;
			pend_addr.delete();
			pend_due.delete();
		end
		else
		begin
			cycle = cycle + 1;
			if (mem_req && accept_q)
			begin
				pend_addr.push_back(mem_addr);
				pend_due.push_back(cycle + int'($urandom_range(MAX_RETURN_DELAY, 1)));
				wait_cnt = $urandom_range(MAX_ACCEPT_WAIT, 0);
			end
			else if (wait_cnt > 0)
			begin
				wait_cnt = wait_cnt - 1;
			end
			accept_q <= (wait_cnt == 0);

			// in order return, the head blocks younger reads
			if (pend_addr.size() > 0 && pend_due[0] <= cycle)
			begin
				return_q <= 1'b1;
				rdata_q  <= contents(pend_addr[0]);
				void'(pend_addr.pop_front());
				void'(pend_due.pop_front());
			end
			else
			begin
				return_q <= 1'b0;
			end
		end
	end

	assign mem_addr_ok = accept_q;
	assign mem_data_ok = return_q;
	assign mem_rdata   = rdata_q;

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter real PERIOD_NS    = 4.0,
	parameter int  RESET_CYCLES = 10
)(
	input  logic restart, // pulse to run the reset sequence again
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	int count = RESET_CYCLES; // reset cycles still to go

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (restart)
			count <= RESET_CYCLES;
		else if (count > 0)
			count <= count - 1;
	end

	assign reset = (count > 0);

endmodule

`default_nettype wire

//--- src/icache.sv
`default_nettype none

module icache #(
	parameter int WAYS       = icache_pkg::DEFAULT_WAYS,
	parameter int SETS       = icache_pkg::DEFAULT_SETS,
	parameter int LINE_WORDS = icache_pkg::DEFAULT_LINE_WORDS
)(
	input  logic                 clk,
	input  logic                 reset,

	input  logic                 req,
	input  icache_pkg::addr_t    addr,
	output logic                 addr_ok,
	output logic                 data_ok,
	output icache_pkg::word_t    rdata,

	output logic                 mem_req,
	output icache_pkg::addr_t    mem_addr,
	input  logic                 mem_addr_ok,
	input  logic                 mem_data_ok,
	input  icache_pkg::word_t    mem_rdata
);

	localparam int OFFSET_WIDTH = $clog2(LINE_WORDS);
	localparam int INDEX_WIDTH  = $clog2(SETS);
	localparam int TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH - 2;
	localparam int WAY_WIDTH    = (WAYS > 1) ? $clog2(WAYS) : 1;

	logic [TAG_WIDTH-1:0]    addr_tag;
	logic [INDEX_WIDTH-1:0]  addr_index;
	logic [OFFSET_WIDTH-1:0] addr_offset;
	icache_pkg::addr_t       line_base;

	logic [WAYS-1:0]                    way_valid;
	logic [WAYS-1:0]                    way_hit;
	logic [WAYS-1:0]                    way_write;
	logic [TAG_WIDTH-1:0]               way_tag  [WAYS];
	icache_pkg::word_t [LINE_WORDS-1:0] way_line [WAYS];
	logic [WAY_WIDTH-1:0]               hit_way;
	logic [WAY_WIDTH-1:0]               victim;
	logic                               hit;

	logic                               miss_q;  // doubles as fill_start
	logic                               filling; // a refill is in flight
	logic                               line_write;
	icache_pkg::word_t [LINE_WORDS-1:0] line_data;

	// tag | index | word offset | byte offset
	assign addr_tag    = addr[31 -: TAG_WIDTH];
	assign addr_index  = addr[OFFSET_WIDTH + 2 +: INDEX_WIDTH];
	assign addr_offset = addr[2 +: OFFSET_WIDTH];
	assign line_base   = {addr_tag, addr_index, {(OFFSET_WIDTH + 2){1'b0}}};

	genvar w;
	generate
		for (w = 0; w < WAYS; w++)
		begin : g_way
			icache_tag_ram #(.SETS(SETS), .TAG_WIDTH(TAG_WIDTH)) tag_ram_inst (
				.clk       (clk),
				.reset     (reset),
				.index     (addr_index),
				.write     (way_write[w]),
				.write_tag (addr_tag),
				.valid     (way_valid[w]),
				.tag       (way_tag[w])
			);

			icache_data_ram #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) data_ram_inst (
				.clk        (clk),
				.index      (addr_index),
				.write      (way_write[w]),
				.write_line (line_data),
				.line       (way_line[w])
			);

			assign way_hit[w]   = way_valid[w] && (way_tag[w] == addr_tag);
			assign way_write[w] = line_write && (victim == WAY_WIDTH'(w)); // victim way only
		end
	endgenerate

	// at most one way can match, so the last match wins without conflict
	always_comb
	begin
		hit_way = '0;
		for (int i = 0; i < WAYS; i++)
		begin
			if (way_hit[i])
			begin
				hit_way = WAY_WIDTH'(i);
			end
		end
	end

	assign hit     = |way_hit;
	assign addr_ok = req & hit;
	assign data_ok = req & hit; // same cycle as addr_ok on a hit
	assign rdata   = way_line[hit_way][addr_offset];

	// register the miss so the refill start does not loop back through the hit logic
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			miss_q  <= 1'b0;
			filling <= 1'b0;
		end
		else
		begin
			miss_q <= req && !hit && !miss_q && !filling;
			if (miss_q)
			begin
				filling <= 1'b1;
			end
			else if (line_write)
			begin
				filling <= 1'b0; // request hits on the next cycle
			end
		end
	end

	icache_replace #(.WAYS(WAYS), .SETS(SETS)) replace_inst (
		.clk    (clk),
		.reset  (reset),
		.index  (addr_index),
		.fill   (line_write),
		.victim (victim)
	);

	icache_refill #(.LINE_WORDS(LINE_WORDS)) refill_inst (
		.clk         (clk),
		.reset       (reset),
		.fill_start  (miss_q),
		.line_base   (line_base),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata),
		.line_write  (line_write),
		.line_data   (line_data)
	);

endmodule

`default_nettype wire

//--- src/icache_data_ram.sv
`default_nettype none

module icache_data_ram #(
	parameter int SETS       = icache_pkg::DEFAULT_SETS,
	parameter int LINE_WORDS = icache_pkg::DEFAULT_LINE_WORDS
)(
	input  logic                                    clk,
	input  logic [$clog2(SETS)-1:0]                 index,
	input  logic                                    write,
	input  icache_pkg::word_t [LINE_WORDS-1:0]      write_line,
	output icache_pkg::word_t [LINE_WORDS-1:0]      line
);

	// one full line per set
	icache_pkg::word_t [LINE_WORDS-1:0] lines [SETS];

	// whole line goes in at once, from the refill engine
	always_ff @(posedge clk)
	begin
		if (write)
		begin
			lines[index] <= write_line;
		end
	end

	assign line = lines[index]; // combinational read

endmodule

`default_nettype wire

//--- src/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// one instruction or memory word
	typedef logic [31:0] word_t;

	// byte address on both the fetch and the memory side
	typedef logic [31:0] addr_t;

	// default geometry, the top level passes these down as parameters
	localparam int DEFAULT_WAYS       = 2;  // associativity
	localparam int DEFAULT_SETS       = 64; // sets per way
	localparam int DEFAULT_LINE_WORDS = 4;  // words per line

endpackage

`default_nettype wire

//--- src/icache_refill.sv
`default_nettype none

module icache_refill #(
	parameter int LINE_WORDS = icache_pkg::DEFAULT_LINE_WORDS
)(
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  fill_start,
	input  icache_pkg::addr_t                     line_base,
	output logic                                  mem_req,
	output icache_pkg::addr_t                     mem_addr,
	input  logic                                  mem_addr_ok,
	input  logic                                  mem_data_ok,
	input  icache_pkg::word_t                     mem_rdata,
	output logic                                  line_write,
	output icache_pkg::word_t [LINE_WORDS-1:0]    line_data
);

	localparam int OFFSET_WIDTH = $clog2(LINE_WORDS);
	localparam int CNT_WIDTH    = OFFSET_WIDTH + 1;
	localparam logic [CNT_WIDTH-1:0] LAST_WORD = CNT_WIDTH'(LINE_WORDS - 1);
	localparam logic [CNT_WIDTH-1:0] ALL_WORDS = CNT_WIDTH'(LINE_WORDS);

	logic                               busy;
	icache_pkg::addr_t                  base_q;   // line aligned base of the miss
	logic [CNT_WIDTH-1:0]               addr_cnt; // addresses accepted so far
	logic [CNT_WIDTH-1:0]               data_cnt; // words returned so far
	icache_pkg::word_t [LINE_WORDS-1:0] line_q;
	logic                               addr_take;
	logic                               data_last;

	// addresses run from offset zero upward, independent of the data side
	assign mem_req   = busy && (addr_cnt != ALL_WORDS);
	assign mem_addr  = base_q | (icache_pkg::addr_t'(addr_cnt) << 2);
	assign addr_take = mem_req & mem_addr_ok;

	// returned data arrives in request order, so data_cnt is the word slot
	assign data_last = busy && mem_data_ok && (data_cnt == LAST_WORD);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy       <= 1'b0;
			addr_cnt   <= '0;
			data_cnt   <= '0;
			line_write <= 1'b0;
		end
		else
		begin
			line_write <= data_last; // one cycle after the last word
			if (fill_start)
			begin
				busy     <= 1'b1;
				addr_cnt <= '0;
				data_cnt <= '0;
			end
			else if (busy)
			begin
				if (addr_take)
				begin
					addr_cnt <= addr_cnt + CNT_WIDTH'(1);
				end
				if (mem_data_ok)
				begin
					data_cnt <= data_cnt + CNT_WIDTH'(1);
				end
				if (data_last)
				begin
					busy <= 1'b0; // idle again while line_write is high
				end
			end
		end
	end

	// line buffer and base
	always_ff @(posedge clk)
	begin
		if (fill_start)
		begin
			base_q <= line_base;
		end
		if (busy && mem_data_ok)
		begin
			line_q[data_cnt[OFFSET_WIDTH-1:0]] <= mem_rdata;
		end
	end

	assign line_data = line_q;

endmodule

`default_nettype wire

//--- src/icache_replace.sv
`default_nettype none

module icache_replace #(
	parameter int WAYS = icache_pkg::DEFAULT_WAYS,
	parameter int SETS = icache_pkg::DEFAULT_SETS
)(
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic [$clog2(SETS)-1:0]                       index,
	input  logic                                          fill,
	output logic [((WAYS > 1) ? $clog2(WAYS) : 1)-1:0]    victim
);

	localparam int WAY_WIDTH = (WAYS > 1) ? $clog2(WAYS) : 1;
	localparam logic [WAY_WIDTH-1:0] LAST_WAY = WAY_WIDTH'(WAYS - 1);

	logic [WAY_WIDTH-1:0] ptr [SETS]; // victim pointer per set
	logic [WAY_WIDTH-1:0] next_ptr;

	// round robin step with wrap
	always_comb
	begin
		if (ptr[index] == LAST_WAY)
		begin
			next_ptr = '0;
		end
		else
		begin
			next_ptr = ptr[index] + WAY_WIDTH'(1);
		end
	end

	// every pointer starts at way 0
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < SETS; s++)
			begin
				ptr[s] <= '0;
			end
		end
		else if (fill)
		begin
			ptr[index] <= next_ptr; // only the set being filled moves
		end
	end

	assign victim = ptr[index];

endmodule

`default_nettype wire

//--- src/icache_tag_ram.sv
`default_nettype none

module icache_tag_ram #(
	parameter int SETS      = icache_pkg::DEFAULT_SETS,
	parameter int TAG_WIDTH = 32 - $clog2(icache_pkg::DEFAULT_SETS)
		- $clog2(icache_pkg::DEFAULT_LINE_WORDS) - 2
)(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [$clog2(SETS)-1:0]  index,
	input  logic                     write,
	input  logic [TAG_WIDTH-1:0]     write_tag,
	output logic                     valid,
	output logic [TAG_WIDTH-1:0]     tag
);

	localparam int INDEX_WIDTH = $clog2(SETS);

	logic [SETS-1:0]      valid_q; // one valid bit per set
	logic [TAG_WIDTH-1:0] tags [SETS];

	// valid bits are control state and clear on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_q <= '0;
		end
		else if (write)
		begin
			valid_q[index] <= 1'b1;
		end
	end

	// tag storage itself
	always_ff @(posedge clk)
	begin
		if (write)
		begin
			tags[index] <= write_tag;
		end
	end

	// read is combinational so the hit compare lands in the request cycle
	assign valid = valid_q[index];
	assign tag   = tags[index[INDEX_WIDTH-1:0]];

endmodule

`default_nettype wire
